//--- cpuCore.f
source/cpuPkg.sv
source/alu.sv
source/busInterface.sv
source/datapath.sv
source/control.sv
source/cpuCore.sv
dv/cpuCoreTb.sv

//--- build.sh
#!/bin/sh
# Compiles the cpuCore testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpuCoreTb -f cpuCore.f -o cpuCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpuCoreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "RESULT: FAIL" "$logFile"; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0

//--- dv/programVectors.txt
# Columns: kind (P program word, D data preload, E expected store), address, data in hex
# E lines list the stores in the order the program performs them
P 0000 72C5
P 0001 75F0
P 0002 7C80
P 0003 0650
P 0004 1850
P 0005 46E0
P 0006 A198
E 0080 0060
P 0007 2650
P 0008 3850
P 0009 46E0
P 000A 8C01
P 000B A198
E 0081 FF35
P 000C 5650
P 000D 6850
P 000E 06E0
P 000F 8C01
P 0010 A198
E 0082 01EC
P 0011 7AF0
P 0012 9740
P 0013 8C01
P 0014 A198
E 0083 BEEF
P 0015 B001
P 0016 A1A8
E 0083 00F0
P 0017 1848
P 0018 B001
P 0019 A188
P 001A C01C
P 001B A188
P 001C 7FFF
P 001D A1E0
E FFFF 0000
D 00F0 BEEF

//--- dv/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

  localparam int          DataWidth   = 16;
  localparam logic [15:0] ResetVector = 16'h0000;
  localparam int          MaxCycles   = 2000;
  localparam int          MaxIdle     = 40;

  logic        Clock;
  logic        reset;
  logic        nWait;
  logic [15:0] DataIn;
  wire  [15:0] DataOut;
  wire         ALE;
  wire         nME;
  wire         nOE;
  wire         nWE;

  logic [15:0] mem [0:65535];
  logic [15:0] expAddr [$];
  logic [15:0] expData [$];
  logic [15:0] cycleAddr;
  logic        addrLatched;
  logic        programDone;
  logic        stalled;
  int          waitsLeft;
  int          idleCycles;
  int          seed;
  int          storeCount;
  int          storeErrors;
  int          protocolErrors;
  int          runErrors;

  cpuCore #(
    .DataWidth   (DataWidth  ),
    .ResetVector (ResetVector)
  ) dut (
    .Clock   (Clock  ),
    .reset   (reset  ),
    .DataIn  (DataIn ),
    .nWait   (nWait  ),
    .DataOut (DataOut),
    .ALE     (ALE    ),
    .nME     (nME    ),
    .nOE     (nOE    ),
    .nWE     (nWE    )
  );

  initial begin
    Clock = 1'b0;
    forever #50 Clock = ~Clock;
  end

  task automatic loadVectors();
    int          fd;
    int          count;
    string       line;
    logic [7:0]  kind;
    logic [15:0] addr;
    logic [15:0] data;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 16'(i) ^ 16'h5A5A;
    end
    fd = $fopen("dv/programVectors.txt", "r");
    if (fd == 0) begin
      runErrors++;
      $display("Could not open the vectors file dv/programVectors.txt");
    end else begin
      while (!$feof(fd)) begin
        count = $fgets(line, fd);
        if (count > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%c %h %h", kind, addr, data) == 3) begin
            case (kind)
              "P", "D": mem[addr] = data;
              "E": begin
                expAddr.push_back(addr);
                expData.push_back(data);
              end
              default: begin
                runErrors++;
                $display("Unknown line kind in the vectors file: %s", line);
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Compares a completed write cycle with the next expected store
  task automatic checkStore(input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] wantAddr;
    logic [15:0] wantData;
    if (expAddr.size() == 0) begin
      storeErrors++;
      $display("A store to %h arrived after all expected stores were used up", addr);
    end else begin
      wantAddr = expAddr.pop_front();
      wantData = expData.pop_front();
      assert (addr == wantAddr) else begin
        storeErrors++;
        $display("CHECK FAILED DataOut store address: got 0x%h, expected 0x%h", addr, wantAddr);
      end
      assert (data == wantData) else begin
        storeErrors++;
        $display("CHECK FAILED DataOut store data: got 0x%h, expected 0x%h", data, wantData);
      end
    end
    mem[addr] = data;
    storeCount++;
    if (addr == 16'hFFFF) begin
      programDone = 1'b1;
    end
  endtask

  // ====================
  // Memory model
  // ====================

  always @(negedge Clock) begin
    if (!reset) begin
      assert (nOE || nWE) else begin
        protocolErrors++;
        $display("nOE and nWE were low together at %0t", $time);
      end
      if (ALE) begin
        cycleAddr   = DataOut;
        addrLatched = 1'b1;
        waitsLeft   = $unsigned($random(seed)) % 3;
        nWait       = 1'b1;
        idleCycles  = 0;
      end else if (!nME) begin
        assert (addrLatched) else begin
          protocolErrors++;
          $display("A strobe phase started without an address phase at %0t", $time);
        end
        assert (!nOE || !nWE) else begin
          protocolErrors++;
          $display("A strobe phase had neither nOE nor nWE low at %0t", $time);
        end
        if (waitsLeft > 0) begin
          // Wrong data while waiting exposes an early sample
          waitsLeft--;
          nWait  = 1'b0;
          DataIn = ~mem[cycleAddr];
        end else begin
          nWait       = 1'b1;
          addrLatched = 1'b0;
          if (!nWE) begin
            checkStore(cycleAddr, DataOut);
          end else begin
            DataIn = mem[cycleAddr];
          end
        end
      end else begin
        nWait = 1'b1;
        idleCycles++;
        if (idleCycles > MaxIdle) begin
          stalled = 1'b1;
        end
      end
    end
  end

  // ====================
  // Sequence
  // ====================

  initial begin
    int cycles;
    seed           = 32'h0069b5b8;
    storeCount     = 0;
    storeErrors    = 0;
    protocolErrors = 0;
    runErrors      = 0;
    idleCycles     = 0;
    waitsLeft      = 0;
    addrLatched    = 1'b0;
    programDone    = 1'b0;
    stalled        = 1'b0;
    cycleAddr      = '0;
    reset          = 1'b1;
    nWait          = 1'b1;
    DataIn         = '0;
    loadVectors();

    repeat (3) @(negedge Clock);
    assert (!ALE && nME && nOE && nWE) else begin
      protocolErrors++;
      $display("CHECK FAILED ALE/nME/nOE/nWE in reset: got 0x%h%h%h%h, expected 0x0111",
               ALE, nME, nOE, nWE);
    end
    reset = 1'b0;

    // The first address phase follows on the next rising edge
    @(posedge Clock);
    @(negedge Clock);
    assert (ALE) else begin
      protocolErrors++;
      $display("CHECK FAILED ALE after reset: got 0x%h, expected 0x1", ALE);
    end
    assert (DataOut == ResetVector) else begin
      protocolErrors++;
      $display("CHECK FAILED DataOut first fetch: got 0x%h, expected 0x%h", DataOut, ResetVector);
    end

    cycles = 0;
    while (!programDone && !stalled && cycles < MaxCycles) begin
      @(negedge Clock);
      cycles++;
    end
    if (stalled) begin
      runErrors++;
      $display("The bus stayed idle for more than %0d cycles", MaxIdle);
    end else if (!programDone) begin
      runErrors++;
      $display("No store to FFFF arrived within %0d cycles", MaxCycles);
    end
    assert (expAddr.size() == 0) else begin
      runErrors++;
      $display("%0d expected stores never happened", expAddr.size());
    end

    $display("Stores %0d, store errors %0d, protocol errors %0d, run errors %0d",
             storeCount, storeErrors, protocolErrors, runErrors);
    if (storeErrors + protocolErrors + runErrors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
  parameter int                   DataWidth   = 16,
  parameter logic [DataWidth-1:0] ResetVector = 16'h0000
) (
  input  wire                 Clock,
  input  wire                 reset,
  input  wire [DataWidth-1:0] DataIn,
  input  wire                 nWait,
  output wire [DataWidth-1:0] DataOut,
  output wire                 ALE,
  output wire                 nME,
  output wire                 nOE,
  output wire                 nWE
);

  cpuPkg::busKindT       busReq;
  logic                  busStart;
  logic                  busDone;
  logic [DataWidth-1:0]  busAddr;
  logic [DataWidth-1:0]  busWrData;
  logic [DataWidth-1:0]  busRdData;
  cpuPkg::aluOpT         aluOp;
  logic                  irWe;
  logic                  pcWe;
  logic                  regWe;
  logic [1:0]            pcSel;
  logic                  addrSel;
  logic                  wdSel;
  logic                  op2Sel;
  cpuPkg::instrT         instr;
  cpuPkg::flagsT         flags;

  control control (
    .Clock     (Clock     ),
    .reset     (reset     ),
    .instr     (instr     ),
    .flags     (flags     ),
    .busDone   (busDone   ),
    .busReq    (busReq    ),
    .busStart  (busStart  ),
    .aluOp     (aluOp     ),
    .irWe      (irWe      ),
    .pcWe      (pcWe      ),
    .regWe     (regWe     ),
    .pcSel     (pcSel     ),
    .addrSel   (addrSel   ),
    .wdSel     (wdSel     ),
    .op2Sel    (op2Sel    )
  );

  datapath #(
    .DataWidth   (DataWidth  ),
    .ResetVector (ResetVector)
  ) datapath (
    .Clock     (Clock     ),
    .reset     (reset     ),
    .aluOp     (aluOp     ),
    .irWe      (irWe      ),
    .pcWe      (pcWe      ),
    .regWe     (regWe     ),
    .pcSel     (pcSel     ),
    .addrSel   (addrSel   ),
    .wdSel     (wdSel     ),
    .op2Sel    (op2Sel    ),
    .busRdData (busRdData ),
    .instr     (instr     ),
    .flags     (flags     ),
    .busAddr   (busAddr   ),
    .busWrData (busWrData )
  );

  busInterface #(
    .DataWidth (DataWidth)
  ) busInterface (
    .Clock     (Clock     ),
    .reset     (reset     ),
    .busReq    (busReq    ),
    .busStart  (busStart  ),
    .busAddr   (busAddr   ),
    .busWrData (busWrData ),
    .DataIn    (DataIn    ),
    .nWait     (nWait     ),
    .busDone   (busDone   ),
    .busRdData (busRdData ),
    .DataOut   (DataOut   ),
    .ALE       (ALE       ),
    .nME       (nME       ),
    .nOE       (nOE       ),
    .nWE       (nWE       )
  );

endmodule

`default_nettype wire

//--- source/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
  input  wire                   Clock,
  input  wire                   reset,
  input  wire cpuPkg::instrT    instr,
  input  wire cpuPkg::flagsT    flags,
  input  wire                   busDone,
  output cpuPkg::busKindT       busReq,
  output logic                  busStart,
  output cpuPkg::aluOpT         aluOp,
  output logic                  irWe,
  output logic                  pcWe,
  output logic                  regWe,
  output logic [1:0]            pcSel,
  output logic                  addrSel,
  output logic                  wdSel,
  output logic                  op2Sel
);

  typedef enum logic [2:0] {
    sFetch, sFetchWait, sDecode, sExecute, sMemWait, sWriteback
  } stateT;

  stateT          state;
  stateT          nextState;
  cpuPkg::opcodeT opcode;
  logic           isAluClass;

  assign opcode = instr.regFmt.opcode;

  // ====================
  // Opcode decode
  // ====================

  always_comb begin
    aluOp      = cpuPkg::aluAdd;
    op2Sel     = 1'b0;
    isAluClass = 1'b1;
    case (opcode)
      cpuPkg::opAdd:  aluOp = cpuPkg::aluAdd;
      cpuPkg::opSub:  aluOp = cpuPkg::aluSub;
      cpuPkg::opAnd:  aluOp = cpuPkg::aluAnd;
      cpuPkg::opOr:   aluOp = cpuPkg::aluOr;
      cpuPkg::opXor:  aluOp = cpuPkg::aluXor;
      cpuPkg::opShl:  aluOp = cpuPkg::aluShl;
      cpuPkg::opShr:  aluOp = cpuPkg::aluShr;
      cpuPkg::opLdi: begin
        aluOp  = cpuPkg::aluPassB;
        op2Sel = 1'b1;
      end
      cpuPkg::opAddi: begin
        aluOp  = cpuPkg::aluAdd;
        op2Sel = 1'b1;
      end
      default: isAluClass = 1'b0;
    endcase
  end

  // ====================
  // Sequencer
  // ====================

  always_comb begin
    nextState = state;
    busReq    = cpuPkg::busNone;
    busStart  = 1'b0;
    irWe      = 1'b0;
    pcWe      = 1'b0;
    regWe     = 1'b0;
    pcSel     = cpuPkg::PcInc;
    addrSel   = 1'b0;
    wdSel     = 1'b0;
    case (state)
      sFetch: begin
        busReq    = cpuPkg::busFetch;
        busStart  = 1'b1;
        nextState = sFetchWait;
      end
      sFetchWait: begin
        if (busDone) begin
          irWe      = 1'b1;
          pcWe      = 1'b1;
          nextState = sDecode;
        end
      end
      sDecode: nextState = sExecute;
      sExecute: begin
        nextState = sFetch;
        if (isAluClass) begin
          regWe = 1'b1;
        end else begin
          case (opcode)
            cpuPkg::opLd: begin
              busReq    = cpuPkg::busRead;
              busStart  = 1'b1;
              addrSel   = 1'b1;
              nextState = sMemWait;
            end
            cpuPkg::opSt: begin
              busReq    = cpuPkg::busWrite;
              busStart  = 1'b1;
              addrSel   = 1'b1;
              nextState = sMemWait;
            end
            cpuPkg::opBz: begin
              pcWe  = flags.zero;
              pcSel = cpuPkg::PcBranch;
            end
            cpuPkg::opJmp: begin
              pcWe  = 1'b1;
              pcSel = cpuPkg::PcJump;
            end
            default: ;
          endcase
        end
      end
      sMemWait: begin
        if (busDone) begin
          nextState = (opcode == cpuPkg::opLd) ? sWriteback : sFetch;
        end
      end
      sWriteback: begin
        regWe     = 1'b1;
        wdSel     = 1'b1;
        nextState = sFetch;
      end
      default: nextState = sFetch;
    endcase
  end

  always_ff @(posedge Clock) begin
    if (reset) begin
      state <= sFetch;
    end else begin
      state <= nextState;
    end
  end

  assert property (@(posedge Clock) disable iff (reset)
    state inside {sFetch, sFetchWait, sDecode, sExecute, sMemWait, sWriteback});

  // Each bus request has to finish before the next one is issued
  assert property (@(posedge Clock) disable iff (reset)
    busStart |=> !busStart throughout busDone[->1]);

endmodule

`default_nettype wire

//--- source/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter int                   DataWidth   = 16,
  parameter logic [DataWidth-1:0] ResetVector = '0
) (
  input  wire                   Clock,
  input  wire                   reset,
  input  wire cpuPkg::aluOpT    aluOp,
  input  wire                   irWe,
  input  wire                   pcWe,
  input  wire                   regWe,
  input  wire [1:0]             pcSel,
  input  wire                   addrSel,
  input  wire                   wdSel,
  input  wire                   op2Sel,
  input  wire [DataWidth-1:0]   busRdData,
  output cpuPkg::instrT         instr,
  output cpuPkg::flagsT         flags,
  output logic [DataWidth-1:0]  busAddr,
  output logic [DataWidth-1:0]  busWrData
);

  logic [DataWidth-1:0] pc;
  logic [DataWidth-1:0] regs [0:7];
  logic [2:0]           readAddrA;
  logic [DataWidth-1:0] regA;
  logic [DataWidth-1:0] regB;
  logic [DataWidth-1:0] immSext;
  logic [DataWidth-1:0] immZext;
  logic [DataWidth-1:0] opB;
  logic [DataWidth-1:0] aluResult;
  cpuPkg::flagsT        aluFlags;
  logic [DataWidth-1:0] writeData;

  // ====================
  // Operands
  // ====================

  // Immediate instructions use rd as both source and destination
  assign readAddrA = op2Sel ? instr.immFmt.rd : instr.regFmt.rs1;

  assign regA = (readAddrA == 3'd0) ? '0 : regs[readAddrA];
  assign regB = (instr.regFmt.rs2 == 3'd0) ? '0 : regs[instr.regFmt.rs2];

  assign immSext = {{(DataWidth-9){instr.immFmt.imm[8]}}, instr.immFmt.imm};
  assign immZext = {{(DataWidth-9){1'b0}}, instr.immFmt.imm};

  assign opB = op2Sel ? immSext : regB;

  alu #(
    .DataWidth (DataWidth)
  ) alu (
    .a      (regA      ),
    .b      (opB       ),
    .aluOp  (aluOp     ),
    .result (aluResult ),
    .flags  (aluFlags  )
  );

  assign writeData = wdSel ? busRdData : aluResult;

  // LD and ST address through rs1, ST data comes from rs2
  assign busAddr   = addrSel ? regA : pc;
  assign busWrData = regB;

  // ====================
  // State
  // ====================

  always_ff @(posedge Clock) begin
    if (irWe) begin
      instr <= busRdData[15:0];
    end
    if (regWe && instr.regFmt.rd != 3'd0) begin
      regs[instr.regFmt.rd] <= writeData;
    end
  end

  always_ff @(posedge Clock) begin
    if (reset) begin
      pc    <= ResetVector;
      flags <= '0;
    end else begin
      if (pcWe) begin
        case (pcSel)
          // The pc already points past the branch here
          cpuPkg::PcBranch: pc <= pc + immSext;
          cpuPkg::PcJump:   pc <= immZext;
          default:          pc <= pc + 1'b1;
        endcase
      end
      // Loads write back too but leave the flags alone
      if (regWe && !wdSel) begin
        flags <= aluFlags;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/busInterface.sv
`timescale 1ns/1ps
`default_nettype none

module busInterface #(
  parameter int DataWidth = 16
) (
  input  wire                   Clock,
  input  wire                   reset,
  input  wire cpuPkg::busKindT  busReq,
  input  wire                   busStart,
  input  wire [DataWidth-1:0]   busAddr,
  input  wire [DataWidth-1:0]   busWrData,
  input  wire [DataWidth-1:0]   DataIn,
  input  wire                   nWait,
  output logic                  busDone,
  output logic [DataWidth-1:0]  busRdData,
  output logic [DataWidth-1:0]  DataOut,
  output logic                  ALE,
  output logic                  nME,
  output logic                  nOE,
  output logic                  nWE
);

  typedef enum logic [1:0] {
    phIdle, phAddress, phStrobe
  } phaseT;

  phaseT                phase;
  logic                 isWrite;
  logic [DataWidth-1:0] wrData;
  logic                 accept;
  logic                 finish;

  assign accept = (phase == phIdle) && busStart && (busReq != cpuPkg::busNone);
  assign finish = (phase == phStrobe) && nWait;

  // ====================
  // Strobes
  // ====================

  always_ff @(posedge Clock) begin
    if (reset) begin
      phase   <= phIdle;
      isWrite <= 1'b0;
      busDone <= 1'b0;
      ALE     <= 1'b0;
      nME     <= 1'b1;
      nOE     <= 1'b1;
      nWE     <= 1'b1;
    end else begin
      busDone <= finish;
      case (phase)
        phIdle: begin
          if (accept) begin
            phase   <= phAddress;
            isWrite <= (busReq == cpuPkg::busWrite);
            ALE     <= 1'b1;
          end
        end
        phAddress: begin
          phase <= phStrobe;
          ALE   <= 1'b0;
          nME   <= 1'b0;
          nOE   <= isWrite;
          nWE   <= !isWrite;
        end
        default: begin
          // Low nWait stretches the strobe phase
          if (nWait) begin
            phase <= phIdle;
            nME   <= 1'b1;
            nOE   <= 1'b1;
            nWE   <= 1'b1;
          end
        end
      endcase
    end
  end

  // Address goes out with ALE, then write data replaces it
  always_ff @(posedge Clock) begin
    if (accept) begin
      DataOut <= busAddr;
      wrData  <= busWrData;
    end else if (phase == phAddress && isWrite) begin
      DataOut <= wrData;
    end
    if (finish && !isWrite) begin
      busRdData <= DataIn;
    end
  end

  assert property (@(posedge Clock) disable iff (reset) !(!nOE && !nWE));

  assert property (@(posedge Clock) disable iff (reset) !(ALE && !nME));

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int DataWidth = 16
) (
  input  wire [DataWidth-1:0]  a,
  input  wire [DataWidth-1:0]  b,
  input  wire cpuPkg::aluOpT   aluOp,
  output logic [DataWidth-1:0] result,
  output cpuPkg::flagsT        flags
);

  localparam int Msb = DataWidth - 1;

  logic [DataWidth:0] sum;

  always_comb begin
    sum    = '0;
    result = '0;
    flags  = '0;
    case (aluOp)
      cpuPkg::aluAdd: begin
        sum            = {1'b0, a} + {1'b0, b};
        result         = sum[Msb:0];
        flags.carry    = sum[DataWidth];
        flags.overflow = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
      end
      cpuPkg::aluSub: begin
        // Carry on subtract is the borrow out
        sum            = {1'b0, a} - {1'b0, b};
        result         = sum[Msb:0];
        flags.carry    = sum[DataWidth];
        flags.overflow = (a[Msb] != b[Msb]) && (sum[Msb] != a[Msb]);
      end
      cpuPkg::aluAnd:   result = a & b;
      cpuPkg::aluOr:    result = a | b;
      cpuPkg::aluXor:   result = a ^ b;
      cpuPkg::aluShl:   result = {a[Msb-1:0], 1'b0};
      cpuPkg::aluShr:   result = {1'b0, a[Msb:1]};
      default:          result = b;
    endcase
    flags.zero     = (result == '0);
    flags.negative = result[Msb];
  end

endmodule

`default_nettype wire

//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // ====================
  // Instruction set
  // ====================

  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opOr   = 4'h3,
    opXor  = 4'h4,
    opShl  = 4'h5,
    opShr  = 4'h6,
    opLdi  = 4'h7,
    opAddi = 4'h8,
    opLd   = 4'h9,
    opSt   = 4'hA,
    opBz   = 4'hB,
    opJmp  = 4'hC
  } opcodeT;

  // Register format, also used by LD (rd <- [rs1]) and ST ([rs1] <- rs2)
  typedef struct packed {
    opcodeT     opcode;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    logic [2:0] unused;
  } instrRegT;

  typedef struct packed {
    opcodeT            opcode;
    logic [2:0]        rd;
    logic signed [8:0] imm;
  } instrImmT;

  typedef union packed {
    instrRegT regFmt;
    instrImmT immFmt;
  } instrT;

  // ====================
  // Datapath and bus
  // ====================

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluShl, aluShr, aluPassB
  } aluOpT;

  typedef enum logic [1:0] {
    busNone, busFetch, busRead, busWrite
  } busKindT;

  typedef struct packed {
    logic zero;
    logic carry;
    logic negative;
    logic overflow;
  } flagsT;

  // Program counter sources
  localparam logic [1:0] PcInc    = 2'd0;
  localparam logic [1:0] PcBranch = 2'd1;
  localparam logic [1:0] PcJump   = 2'd2;

endpackage

`default_nettype wire
